// File: flist.f
hdl/store_cfg_pkg.sv
hdl/store_types_pkg.sv
hdl/store_bank_if.sv
hdl/store_addr_bank.sv
hdl/store_data_bank.sv
hdl/store_issue_stage.sv
hdl/store_issue_queue.sv
verif/tb_clk_gen.sv
verif/store_issue_queue_props.sv
verif/tb_store_issue_queue.sv

// File: Bender.yml
package:
  name: store_issue_queue

sources:
  - files:
      - hdl/store_cfg_pkg.sv
      - hdl/store_types_pkg.sv
      - hdl/store_bank_if.sv
      - hdl/store_addr_bank.sv
      - hdl/store_data_bank.sv
      - hdl/store_issue_stage.sv
      - hdl/store_issue_queue.sv
  - target: test
    files:
      - verif/tb_clk_gen.sv
      - verif/store_issue_queue_props.sv
      - verif/tb_store_issue_queue.sv

// File: verif/tb_store_issue_queue.sv
`timescale 1ns/1ns

module tb_store_issue_queue;

    localparam int BANK_SIZE = 8;
    localparam int IDX_W     = $clog2(BANK_SIZE);
    localparam int WB        = store_cfg_pkg::WB_PORTS;
    localparam int PREG_W    = store_cfg_pkg::PREG_W;
    localparam int WAIT_LIM  = 20;
    localparam int RUN_LIM   = 2000;   // all tests with margin

    logic clk;
    logic rst;
    logic dis_en;
    logic full;
    logic redirect;
    logic reply_en;
    logic reply_success;
    logic addr_issue;
    logic data_issue;
    logic [IDX_W-1:0] reply_entry;
    logic [WB-1:0] wb_en;
    logic [WB-1:0][PREG_W-1:0] wb_preg;
    store_types_pkg::store_dis_t dis_data;
    store_types_pkg::rob_idx_t redirect_rob;
    store_types_pkg::store_addr_issue_t addr_issue_data;
    store_types_pkg::store_data_issue_t data_issue_data;

    int cyc = 0;
    int errors = 0;
    int addr_cyc_q[$];
    int data_cyc_q[$];
    store_types_pkg::store_addr_issue_t addr_q[$];
    store_types_pkg::store_data_issue_t data_q[$];
    store_types_pkg::rob_idx_t rob_next;
    store_types_pkg::store_dis_t stores[BANK_SIZE];
    logic [PREG_W-1:0] tag_base;

    tb_clk_gen #(.PERIOD(8), .RST_CYCLES(10)) clk_gen_i (.clk_o(clk), .rst_o(rst));

    store_issue_queue #(.BANK_SIZE(BANK_SIZE)) dut_i (
        .clk(clk), .rst(rst),
        .dis_en_i(dis_en), .dis_data_i(dis_data), .full_o(full),
        .wb_en_i(wb_en), .wb_preg_i(wb_preg),
        .redirect_i(redirect), .redirect_rob_i(redirect_rob),
        .reply_en_i(reply_en), .reply_success_i(reply_success),
        .reply_entry_i(reply_entry),
        .addr_issue_o(addr_issue), .addr_issue_data_o(addr_issue_data),
        .data_issue_o(data_issue), .data_issue_data_o(data_issue_data)
    );

    always @(posedge clk) cyc <= cyc + 1;

    // issue capture at the falling edge
    always @(negedge clk) begin
        if (!rst && addr_issue) begin
            addr_cyc_q.push_back(cyc);
            addr_q.push_back(addr_issue_data);
        end
        if (!rst && data_issue) begin
            data_cyc_q.push_back(cyc);
            data_q.push_back(data_issue_data);
        end
    end

    initial begin
        repeat (RUN_LIM) @(posedge clk);
        $display("watchdog expired after %0d cycles, run stopped", RUN_LIM);
        $display("TEST FAILED");
        $finish;
    end

    task automatic check_true(input bit ok, input string msg);
        assert (ok) else begin
            errors++;
            $display("[FAIL] %0t %s", $time, msg);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    function automatic logic [1:0] expected_size(store_types_pkg::mem_op_e op);
        if (op == store_types_pkg::store_word) return 2'd2;
        if (op == store_types_pkg::store_half) return 2'd1;
        return 2'd0;
    endfunction

    function automatic logic is_older(store_types_pkg::rob_idx_t a,
                                      store_types_pkg::rob_idx_t b);
        if (a.dir == b.dir) return a.idx < b.idx;
        return a.idx > b.idx;
    endfunction

    task automatic make_store(input logic r1v, input logic r2v, input logic [PREG_W-1:0] t1,
                              input logic [PREG_W-1:0] t2,
                              output store_types_pkg::store_dis_t s);
        s.memop   = store_types_pkg::mem_op_e'($urandom_range(0, 2));
        s.imm     = store_cfg_pkg::IMM_W'($urandom);
        s.rs1     = t1;
        s.rs1v    = r1v;
        s.rs2     = t2;
        s.rs2v    = r2v;
        s.rob_idx = rob_next;
        s.sq_idx  = store_cfg_pkg::SQ_W'($urandom);
        {rob_next.dir, rob_next.idx} = {rob_next.dir, rob_next.idx} + 1'b1;   // ring wrap
    endtask

    task automatic dispatch(input store_types_pkg::store_dis_t s, output int at);
        at       = cyc;
        dis_en   = 1'b1;
        dis_data = s;
        next_cycle();
        dis_en   = 1'b0;
    endtask

    task automatic wake(input logic [PREG_W-1:0] t0, input logic [PREG_W-1:0] t1,
                        input logic [WB-1:0] en, output int at);
        at         = cyc;
        wb_en      = en;
        wb_preg[0] = t0;
        wb_preg[1] = t1;
        next_cycle();
        wb_en      = '0;
    endtask

    task automatic send_reply(input logic [IDX_W-1:0] entry, input logic success);
        reply_en      = 1'b1;
        reply_success = success;
        reply_entry   = entry;
        next_cycle();
        reply_en      = 1'b0;
    endtask

    task automatic pop_addr(output store_types_pkg::store_addr_issue_t a, output int at);
        int n;
        n = 0;
        while (addr_q.size() == 0 && n < WAIT_LIM) begin
            next_cycle();
            n++;
        end
        a  = '0;
        at = -1;
        if (addr_q.size() == 0) begin
            errors++;
            $display("no address issue within %0d cycles at %0t", WAIT_LIM, $time);
        end else begin
            a  = addr_q.pop_front();
            at = addr_cyc_q.pop_front();
        end
    endtask

    task automatic pop_data(output store_types_pkg::store_data_issue_t d, output int at);
        int n;
        n = 0;
        while (data_q.size() == 0 && n < WAIT_LIM) begin
            next_cycle();
            n++;
        end
        d  = '0;
        at = -1;
        if (data_q.size() == 0) begin
            errors++;
            $display("no data issue within %0d cycles at %0t", WAIT_LIM, $time);
        end else begin
            d  = data_q.pop_front();
            at = data_cyc_q.pop_front();
        end
    endtask

    task automatic check_addr(input store_types_pkg::store_addr_issue_t a,
                              input store_types_pkg::store_dis_t s);
        check_true(a.rob_idx == s.rob_idx, "address issue rob_idx mismatch");
        check_true(a.sq_idx == s.sq_idx, "address issue sq_idx mismatch");
        check_true(a.imm == s.imm, "address issue imm mismatch");
        check_true(a.size == expected_size(s.memop), "address issue size mismatch");
    endtask

    task automatic check_data(input store_types_pkg::store_data_issue_t d,
                              input store_types_pkg::store_dis_t s);
        check_true(d.rob_idx == s.rob_idx, "data issue rob_idx mismatch");
        check_true(d.sq_idx == s.sq_idx, "data issue sq_idx mismatch");
        check_true(d.size == expected_size(s.memop), "data issue size mismatch");
        check_true(d.rs2 == s.rs2, "data issue rs2 mismatch");
    endtask

    task automatic expect_quiet(input int n);
        repeat (n) next_cycle();
        check_true(addr_q.size() == 0, "unexpected address issue");
        check_true(data_q.size() == 0, "unexpected data issue");
        addr_q.delete();
        addr_cyc_q.delete();
        data_q.delete();
        data_cyc_q.delete();
    endtask

    initial begin
        store_types_pkg::store_dis_t s;
        store_types_pkg::store_addr_issue_t a;
        store_types_pkg::store_data_issue_t d;
        int t0;
        int t1;
        int ta;
        int td;

        dis_en        = 1'b0;
        dis_data      = '0;
        wb_en         = '0;
        wb_preg       = '0;
        redirect      = 1'b0;
        redirect_rob  = '0;
        reply_en      = 1'b0;
        reply_success = 1'b0;
        reply_entry   = '0;
        void'($urandom(32'h6690d611));
        rob_next = store_types_pkg::rob_idx_t'($urandom);
        tag_base = PREG_W'($urandom);

        // reset
        @(negedge rst);
        next_cycle();
        repeat (4) begin
            check_true(!full && !addr_issue && !data_issue, "output high after reset");
            next_cycle();
        end

        // ready store issues two cycles after select
        make_store(1'b1, 1'b1, tag_base, tag_base + 7'd1, s);
        dispatch(s, t0);
        pop_addr(a, ta);
        pop_data(d, td);
        check_true(ta == t0 + 3, "address issue latency wrong");
        check_true(td == t0 + 3, "data issue latency wrong");
        check_addr(a, s);
        check_data(d, s);
        send_reply(a.entry[IDX_W-1:0], 1'b1);
        expect_quiet(6);

        // rs1 and rs2 wake separately
        make_store(1'b0, 1'b0, tag_base + 7'd2, tag_base + 7'd3, s);
        dispatch(s, t0);
        expect_quiet(6);
        wake(s.rs1, '0, 2'b01, t1);
        pop_addr(a, ta);
        check_true(ta == t1 + 3, "address issue after wakeup latency wrong");
        check_addr(a, s);
        check_true(data_q.size() == 0, "data issued before rs2 wakeup");
        wake('0, s.rs2, 2'b10, t1);
        pop_data(d, td);
        check_true(td == t1 + 3, "data issue after wakeup latency wrong");
        check_data(d, s);
        send_reply(a.entry[IDX_W-1:0], 1'b1);
        expect_quiet(6);

        // fill both banks and drain
        for (int i = 0; i < BANK_SIZE; i++) begin
            make_store(1'b0, 1'b0, tag_base + PREG_W'(2 * i), tag_base + PREG_W'(2 * i + 1), s);
            stores[i] = s;
            dispatch(s, t0);
        end
        check_true(full, "full_o low with all entries taken");
        make_store(1'b1, 1'b1, tag_base + 7'd100, tag_base + 7'd101, s);
        dis_en   = 1'b1;
        dis_data = s;
        repeat (3) next_cycle();
        dis_en = 1'b0;
        check_true(full, "full_o dropped on dispatch into full queue");
        expect_quiet(6);
        for (int i = 0; i < BANK_SIZE; i++) begin
            wake(stores[i].rs1, stores[i].rs2, 2'b11, t1);
        end
        for (int i = 0; i < BANK_SIZE; i++) begin
            pop_addr(a, ta);
            check_addr(a, stores[i]);
            send_reply(a.entry[IDX_W-1:0], 1'b1);
            pop_data(d, td);
            check_data(d, stores[i]);
        end
        next_cycle();
        check_true(!full, "full_o still high after draining");
        expect_quiet(6);

        // replay then success
        make_store(1'b1, 1'b1, tag_base, tag_base + 7'd1, s);
        dispatch(s, t0);
        pop_addr(a, ta);
        check_addr(a, s);
        send_reply(a.entry[IDX_W-1:0], 1'b0);
        pop_addr(a, ta);
        check_addr(a, s);
        send_reply(a.entry[IDX_W-1:0], 1'b1);
        pop_data(d, td);
        check_data(d, s);
        expect_quiet(8);

        // redirect walk keeps the two oldest
        for (int i = 0; i < 4; i++) begin
            make_store(1'b0, 1'b0, tag_base + PREG_W'(2 * i), tag_base + PREG_W'(2 * i + 1), s);
            stores[i] = s;
            dispatch(s, t0);
        end
        redirect     = 1'b1;
        redirect_rob = stores[2].rob_idx;
        next_cycle();
        redirect = 1'b0;
        for (int i = 0; i < 4; i++) begin
            wake(stores[i].rs1, stores[i].rs2, 2'b11, t1);
        end
        for (int i = 0; i < 2; i++) begin
            pop_addr(a, ta);
            check_addr(a, stores[i]);
            check_true(is_older(a.rob_idx, redirect_rob), "address issue younger than redirect");
            send_reply(a.entry[IDX_W-1:0], 1'b1);
            pop_data(d, td);
            check_data(d, stores[i]);
        end
        expect_quiet(8);

        // redirect in the select cycle
        make_store(1'b1, 1'b1, tag_base, tag_base + 7'd1, s);
        dispatch(s, t0);
        redirect     = 1'b1;
        redirect_rob = s.rob_idx;
        next_cycle();
        redirect = 1'b0;
        expect_quiet(8);

        // redirect while a selection is in flight
        make_store(1'b1, 1'b1, tag_base, tag_base + 7'd1, s);
        dispatch(s, t0);
        next_cycle();
        redirect     = 1'b1;
        redirect_rob = s.rob_idx;
        next_cycle();
        redirect = 1'b0;
        expect_quiet(8);

        $display("errors: %0d check, %0d property", errors, dut_i.props_i.fail_cnt);
        if (errors == 0 && dut_i.props_i.fail_cnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: verif/store_issue_queue_props.sv
`timescale 1ns/1ns

module store_issue_queue_props (
    input logic                               clk,
    input logic                               rst,
    input logic                               dis_en_i,
    input logic                               full_o,
    input logic                               redirect_i,
    input store_types_pkg::rob_idx_t          redirect_rob_i,
    input logic                               addr_issue_o,
    input store_types_pkg::store_addr_issue_t addr_issue_data_o,
    input logic                               data_issue_o,
    input store_types_pkg::store_data_issue_t data_issue_data_o
);

    int unsigned fail_cnt = 0;

    // wrap bit flip inverts the idx compare
    function automatic logic is_older(store_types_pkg::rob_idx_t a,
                                      store_types_pkg::rob_idx_t b);
        if (a.dir == b.dir) begin
            return a.idx < b.idx;
        end
        return a.idx > b.idx;
    endfunction

    reset_quiet: assert property (@(posedge clk)
        rst |=> !addr_issue_o && !data_issue_o && !full_o)
        else begin
            $error("issue strobe or full high during reset");
            fail_cnt++;
        end

    full_holds: assert property (@(posedge clk) disable iff (rst)
        full_o && dis_en_i && !redirect_i |=> full_o)
        else begin
            $error("dispatch into a full queue changed state");
            fail_cnt++;
        end

    // in-flight stage dropped on redirect
    addr_flush_1: assert property (@(posedge clk) disable iff (rst)
        redirect_i |=> !addr_issue_o ||
            is_older(addr_issue_data_o.rob_idx, $past(redirect_rob_i)))
        else begin
            $error("address issue younger than redirect, one cycle after");
            fail_cnt++;
        end

    addr_flush_2: assert property (@(posedge clk) disable iff (rst)
        redirect_i |=> ##1 (!addr_issue_o ||
            is_older(addr_issue_data_o.rob_idx, $past(redirect_rob_i, 2))))
        else begin
            $error("address issue younger than redirect, two cycles after");
            fail_cnt++;
        end

    data_flush_1: assert property (@(posedge clk) disable iff (rst)
        redirect_i |=> !data_issue_o ||
            is_older(data_issue_data_o.rob_idx, $past(redirect_rob_i)))
        else begin
            $error("data issue younger than redirect, one cycle after");
            fail_cnt++;
        end

    data_flush_2: assert property (@(posedge clk) disable iff (rst)
        redirect_i |=> ##1 (!data_issue_o ||
            is_older(data_issue_data_o.rob_idx, $past(redirect_rob_i, 2))))
        else begin
            $error("data issue younger than redirect, two cycles after");
            fail_cnt++;
        end

endmodule

bind store_issue_queue store_issue_queue_props props_i (.*);

// File: verif/tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen #(
    parameter int PERIOD     = 8,
    parameter int RST_CYCLES = 10
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_o = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_o);
        #1 rst_o = 1'b0;   // release off the edge
    end

endmodule

// File: hdl/store_issue_queue.sv
`timescale 1ns/1ns

module store_issue_queue #(
    parameter int BANK_SIZE = 8
) (
    input  logic                                      clk,
    input  logic                                      rst,

    input  logic                                      dis_en_i,
    input  store_types_pkg::store_dis_t               dis_data_i,
    output logic                                      full_o,

    input  logic [store_cfg_pkg::WB_PORTS-1:0]        wb_en_i,
    input  logic [store_cfg_pkg::WB_PORTS-1:0][store_cfg_pkg::PREG_W-1:0] wb_preg_i,

    input  logic                                      redirect_i,
    input  store_types_pkg::rob_idx_t                 redirect_rob_i,

    input  logic                                      reply_en_i,
    input  logic                                      reply_success_i,   // low means replay
    input  logic [$clog2(BANK_SIZE)-1:0]              reply_entry_i,

    output logic                                      addr_issue_o,
    output store_types_pkg::store_addr_issue_t        addr_issue_data_o,
    output logic                                      data_issue_o,
    output store_types_pkg::store_data_issue_t        data_issue_data_o
);

    logic dis_en;
    logic addr_full;
    logic data_full;

    store_bank_if addr_sel_if ();
    store_bank_if data_sel_if ();

    assign full_o = addr_full | data_full;
    assign dis_en = dis_en_i & ~full_o;   // both banks take the store or neither

    store_addr_bank #(
        .BANK_SIZE (BANK_SIZE)
    ) addr_bank_i (
        .clk             (clk),
        .rst             (rst),
        .dis_en_i        (dis_en),
        .dis_data_i      (dis_data_i),
        .wb_en_i         (wb_en_i),
        .wb_preg_i       (wb_preg_i),
        .redirect_i      (redirect_i),
        .redirect_rob_i  (redirect_rob_i),
        .reply_en_i      (reply_en_i),
        .reply_success_i (reply_success_i),
        .reply_entry_i   (reply_entry_i),
        .full_o          (addr_full),
        .sel_io          (addr_sel_if.bank)
    );

    store_data_bank #(
        .BANK_SIZE (BANK_SIZE)
    ) data_bank_i (
        .clk            (clk),
        .rst            (rst),
        .dis_en_i       (dis_en),
        .dis_data_i     (dis_data_i),
        .wb_en_i        (wb_en_i),
        .wb_preg_i      (wb_preg_i),
        .redirect_i     (redirect_i),
        .redirect_rob_i (redirect_rob_i),
        .full_o         (data_full),
        .sel_io         (data_sel_if.bank)
    );

    store_issue_stage #(
        .BANK_SIZE (BANK_SIZE)
    ) issue_stage_i (
        .clk               (clk),
        .rst               (rst),
        .addr_io           (addr_sel_if.issue),
        .data_io           (data_sel_if.issue),
        .redirect_i        (redirect_i),
        .redirect_rob_i    (redirect_rob_i),
        .addr_issue_o      (addr_issue_o),
        .addr_issue_data_o (addr_issue_data_o),
        .data_issue_o      (data_issue_o),
        .data_issue_data_o (data_issue_data_o)
    );

endmodule

// File: hdl/store_issue_stage.sv
`timescale 1ns/1ns

module store_issue_stage #(
    parameter int BANK_SIZE = 8
) (
    input  logic                               clk,
    input  logic                               rst,
    store_bank_if.issue                        addr_io,
    store_bank_if.issue                        data_io,
    input  logic                               redirect_i,
    input  store_types_pkg::rob_idx_t          redirect_rob_i,
    output logic                               addr_issue_o,
    output store_types_pkg::store_addr_issue_t addr_issue_data_o,
    output logic                               data_issue_o,
    output store_types_pkg::store_data_issue_t data_issue_data_o
);

    localparam int IDX_W   = $clog2(BANK_SIZE);
    localparam int ENTRY_W = store_cfg_pkg::ENTRY_W;

    logic                               addr_keep;
    logic                               data_keep;
    logic [ENTRY_W-1:0]                 addr_entry;
    store_types_pkg::store_addr_issue_t addr_payload;

    // in-flight item survives unless a redirect makes it stale
    assign addr_keep = ~redirect_i |
                       store_types_pkg::rob_older(addr_io.sel_rob_idx, redirect_rob_i);
    assign data_keep = ~redirect_i |
                       store_types_pkg::rob_older(data_io.sel_rob_idx, redirect_rob_i);

    // only the bank index bits carry meaning
    assign addr_entry = ENTRY_W'(addr_io.addr_data.entry[IDX_W-1:0]);

    always_comb begin
        addr_payload       = addr_io.addr_data;
        addr_payload.entry = addr_entry;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            addr_issue_o <= 1'b0;
            data_issue_o <= 1'b0;
        end else begin
            addr_issue_o <= addr_io.sel_valid & addr_keep;
            data_issue_o <= data_io.sel_valid & data_keep;
        end
    end

    always_ff @(posedge clk) begin
        addr_issue_data_o <= addr_payload;
        data_issue_data_o <= data_io.data_data;
    end

endmodule

// File: hdl/store_data_bank.sv
`timescale 1ns/1ns

module store_data_bank #(
    parameter int BANK_SIZE = 8
) (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic                                      dis_en_i,
    input  store_types_pkg::store_dis_t               dis_data_i,
    input  logic [store_cfg_pkg::WB_PORTS-1:0]        wb_en_i,
    input  logic [store_cfg_pkg::WB_PORTS-1:0][store_cfg_pkg::PREG_W-1:0] wb_preg_i,
    input  logic                                      redirect_i,
    input  store_types_pkg::rob_idx_t                 redirect_rob_i,
    output logic                                      full_o,
    store_bank_if.bank                                sel_io
);

    localparam int IDX_W = $clog2(BANK_SIZE);

    logic [BANK_SIZE-1:0] valid_q;
    logic [BANK_SIZE-1:0] rs2v_q;

    logic [store_cfg_pkg::PREG_W-1:0] rs2_q  [BANK_SIZE];
    store_types_pkg::rob_idx_t        rob_q  [BANK_SIZE];
    logic [store_cfg_pkg::SQ_W-1:0]   sq_q   [BANK_SIZE];
    logic [1:0]                       size_q [BANK_SIZE];

    logic [BANK_SIZE-1:0] ready;
    logic [BANK_SIZE-1:0] wake;
    logic [BANK_SIZE-1:0] keep;
    logic [IDX_W-1:0]     free_idx;
    logic [IDX_W-1:0]     sel_idx;
    logic                 sel_fire;
    logic                 dis_wake;

    logic                               sel_valid_q;
    store_types_pkg::store_data_issue_t sel_data_q;

    always_comb begin
        dis_wake = 1'b0;
        for (int j = 0; j < store_cfg_pkg::WB_PORTS; j++) begin
            dis_wake = dis_wake | (wb_en_i[j] && (wb_preg_i[j] == dis_data_i.rs2));
        end
        free_idx = '0;
        sel_idx  = '0;
        for (int i = BANK_SIZE-1; i >= 0; i--) begin
            wake[i] = 1'b0;
            for (int j = 0; j < store_cfg_pkg::WB_PORTS; j++) begin
                wake[i] = wake[i] | (wb_en_i[j] && (wb_preg_i[j] == rs2_q[i]));
            end
            ready[i] = valid_q[i] & rs2v_q[i];
            keep[i]  = store_types_pkg::rob_older(rob_q[i], redirect_rob_i);
            if (!valid_q[i]) begin
                free_idx = IDX_W'(i);
            end
            if (ready[i]) begin
                sel_idx = IDX_W'(i);   // lowest ready wins
            end
        end
    end

    assign sel_fire = (|ready) & ~redirect_i;
    assign full_o   = &valid_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q     <= '0;
            rs2v_q      <= '0;
            sel_valid_q <= 1'b0;
        end else begin
            if (redirect_i) begin
                valid_q <= valid_q & keep;
            end else begin
                if (dis_en_i) begin
                    valid_q[free_idx] <= 1'b1;
                end
                // no reply for data, slot goes free on select
                if (sel_fire) begin
                    valid_q[sel_idx] <= 1'b0;
                end
            end

            for (int i = 0; i < BANK_SIZE; i++) begin
                if (dis_en_i && (free_idx == IDX_W'(i))) begin
                    rs2v_q[i] <= dis_data_i.rs2v | dis_wake;
                end else begin
                    rs2v_q[i] <= rs2v_q[i] | wake[i];
                end
            end

            sel_valid_q <= sel_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (dis_en_i) begin
            rs2_q[free_idx]  <= dis_data_i.rs2;
            rob_q[free_idx]  <= dis_data_i.rob_idx;
            sq_q[free_idx]   <= dis_data_i.sq_idx;
            size_q[free_idx] <= store_types_pkg::mem_size(dis_data_i.memop);
        end
        sel_data_q.rob_idx <= rob_q[sel_idx];
        sel_data_q.sq_idx  <= sq_q[sel_idx];
        sel_data_q.size    <= size_q[sel_idx];
        sel_data_q.rs2     <= rs2_q[sel_idx];
    end

    assign sel_io.sel_valid   = sel_valid_q;
    assign sel_io.sel_rob_idx = sel_data_q.rob_idx;
    assign sel_io.data_data   = sel_data_q;
    assign sel_io.addr_data   = '0;   // address payload unused here

endmodule

// File: hdl/store_addr_bank.sv
`timescale 1ns/1ns

module store_addr_bank #(
    parameter int BANK_SIZE = 8
) (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic                                      dis_en_i,
    input  store_types_pkg::store_dis_t               dis_data_i,
    input  logic [store_cfg_pkg::WB_PORTS-1:0]        wb_en_i,
    input  logic [store_cfg_pkg::WB_PORTS-1:0][store_cfg_pkg::PREG_W-1:0] wb_preg_i,
    input  logic                                      redirect_i,
    input  store_types_pkg::rob_idx_t                 redirect_rob_i,
    input  logic                                      reply_en_i,
    input  logic                                      reply_success_i,
    input  logic [$clog2(BANK_SIZE)-1:0]              reply_entry_i,
    output logic                                      full_o,
    store_bank_if.bank                                sel_io
);

    localparam int IDX_W   = $clog2(BANK_SIZE);
    localparam int ENTRY_W = store_cfg_pkg::ENTRY_W;

    logic [BANK_SIZE-1:0] valid_q;
    logic [BANK_SIZE-1:0] issued_q;
    logic [BANK_SIZE-1:0] rs1v_q;

    logic [store_cfg_pkg::PREG_W-1:0] rs1_q  [BANK_SIZE];
    store_types_pkg::rob_idx_t        rob_q  [BANK_SIZE];
    logic [store_cfg_pkg::IMM_W-1:0]  imm_q  [BANK_SIZE];
    logic [store_cfg_pkg::SQ_W-1:0]   sq_q   [BANK_SIZE];
    logic [1:0]                       size_q [BANK_SIZE];

    logic [BANK_SIZE-1:0] ready;
    logic [BANK_SIZE-1:0] wake;
    logic [BANK_SIZE-1:0] keep;
    logic [IDX_W-1:0]     free_idx;
    logic [IDX_W-1:0]     sel_idx;
    logic                 sel_fire;
    logic                 dis_wake;

    logic                               sel_valid_q;
    store_types_pkg::store_addr_issue_t sel_data_q;

    // wakeup compare, readiness and redirect age per entry
    always_comb begin
        dis_wake = 1'b0;
        for (int j = 0; j < store_cfg_pkg::WB_PORTS; j++) begin
            dis_wake = dis_wake | (wb_en_i[j] && (wb_preg_i[j] == dis_data_i.rs1));
        end
        for (int i = 0; i < BANK_SIZE; i++) begin
            wake[i] = 1'b0;
            for (int j = 0; j < store_cfg_pkg::WB_PORTS; j++) begin
                wake[i] = wake[i] | (wb_en_i[j] && (wb_preg_i[j] == rs1_q[i]));
            end
            ready[i] = valid_q[i] & rs1v_q[i] & ~issued_q[i];
            keep[i]  = store_types_pkg::rob_older(rob_q[i], redirect_rob_i);
        end
    end

    // lowest free and lowest ready slot
    always_comb begin
        free_idx = '0;
        sel_idx  = '0;
        for (int i = BANK_SIZE-1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                free_idx = IDX_W'(i);
            end
            if (ready[i]) begin
                sel_idx = IDX_W'(i);
            end
        end
    end

    assign sel_fire = (|ready) & ~redirect_i;
    assign full_o   = &valid_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q     <= '0;
            issued_q    <= '0;
            rs1v_q      <= '0;
            sel_valid_q <= 1'b0;
        end else begin
            if (redirect_i) begin
                valid_q <= valid_q & keep;   // walk
            end else if (dis_en_i) begin
                valid_q[free_idx] <= 1'b1;
            end
            if (reply_en_i && reply_success_i) begin
                valid_q[reply_entry_i] <= 1'b0;
            end

            if (dis_en_i) begin
                issued_q[free_idx] <= 1'b0;
            end
            if (sel_fire) begin
                issued_q[sel_idx] <= 1'b1;
            end
            // replay clears issued
            if (reply_en_i && !reply_success_i) begin
                issued_q[reply_entry_i] <= 1'b0;
            end

            for (int i = 0; i < BANK_SIZE; i++) begin
                if (dis_en_i && (free_idx == IDX_W'(i))) begin
                    rs1v_q[i] <= dis_data_i.rs1v | dis_wake;
                end else begin
                    rs1v_q[i] <= rs1v_q[i] | wake[i];
                end
            end

            sel_valid_q <= sel_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (dis_en_i) begin
            rs1_q[free_idx]  <= dis_data_i.rs1;
            rob_q[free_idx]  <= dis_data_i.rob_idx;
            imm_q[free_idx]  <= dis_data_i.imm;
            sq_q[free_idx]   <= dis_data_i.sq_idx;
            size_q[free_idx] <= store_types_pkg::mem_size(dis_data_i.memop);
        end
        sel_data_q.rob_idx <= rob_q[sel_idx];
        sel_data_q.sq_idx  <= sq_q[sel_idx];
        sel_data_q.imm     <= imm_q[sel_idx];
        sel_data_q.size    <= size_q[sel_idx];
        sel_data_q.entry   <= ENTRY_W'(sel_idx);
    end

    assign sel_io.sel_valid   = sel_valid_q;
    assign sel_io.sel_rob_idx = sel_data_q.rob_idx;
    assign sel_io.addr_data   = sel_data_q;
    assign sel_io.data_data   = '0;   // data payload unused here

endmodule

// File: hdl/store_bank_if.sv
`timescale 1ns/1ns

interface store_bank_if;

    logic                                sel_valid;
    store_types_pkg::rob_idx_t           sel_rob_idx;

    // each bank fills only its own payload
    store_types_pkg::store_addr_issue_t  addr_data;
    store_types_pkg::store_data_issue_t  data_data;

    modport bank (
        output sel_valid,
        output sel_rob_idx,
        output addr_data,
        output data_data
    );

    modport issue (
        input sel_valid,
        input sel_rob_idx,
        input addr_data,
        input data_data
    );

endinterface

// File: hdl/store_types_pkg.sv
package store_types_pkg;

    typedef enum logic [1:0] {
        store_byte,
        store_half,
        store_word
    } mem_op_e;

    typedef struct packed {
        logic                            dir;   // wrap bit
        logic [store_cfg_pkg::ROB_W-1:0] idx;
    } rob_idx_t;

    typedef struct packed {
        mem_op_e                          memop;
        logic [store_cfg_pkg::IMM_W-1:0]  imm;
        logic [store_cfg_pkg::PREG_W-1:0] rs1;
        logic                             rs1v;
        logic [store_cfg_pkg::PREG_W-1:0] rs2;
        logic                             rs2v;
        rob_idx_t                         rob_idx;
        logic [store_cfg_pkg::SQ_W-1:0]   sq_idx;
    } store_dis_t;

    typedef struct packed {
        rob_idx_t                          rob_idx;
        logic [store_cfg_pkg::SQ_W-1:0]    sq_idx;
        logic [store_cfg_pkg::IMM_W-1:0]   imm;
        logic [1:0]                        size;
        logic [store_cfg_pkg::ENTRY_W-1:0] entry;   // address bank slot for the reply
    } store_addr_issue_t;

    typedef struct packed {
        rob_idx_t                         rob_idx;
        logic [store_cfg_pkg::SQ_W-1:0]   sq_idx;
        logic [1:0]                       size;
        logic [store_cfg_pkg::PREG_W-1:0] rs2;
    } store_data_issue_t;

    // access size, 0 byte, 1 half, 2 word
    function automatic logic [1:0] mem_size(mem_op_e op);
        case (op)
            store_half: return 2'd1;
            store_word: return 2'd2;
            default:    return 2'd0;
        endcase
    endfunction

    // a older than b, wrap bit flips the compare
    function automatic logic rob_older(rob_idx_t a, rob_idx_t b);
        return (a.dir ^ b.dir) ^ (b.idx > a.idx);
    endfunction

endpackage

// File: hdl/store_cfg_pkg.sv
package store_cfg_pkg;

    // physical register tag
    localparam int PREG_W = 7;

    // rob index field, wrap bit not included
    localparam int ROB_W = 6;

    // store queue index
    localparam int SQ_W = 5;

    // writeback bus ports
    localparam int WB_PORTS = 2;

    localparam int IMM_W = 12;

    // entry index field in the issue payload, enough for 16-entry banks
    localparam int ENTRY_W = 4;

endpackage
